// File: sim.f
+incdir+include
source/rvfi_pkg.sv
source/spec_pkg.sv
source/spec_if.sv
source/insn_count_checker.sv
source/insn_logic_checker.sv
source/insn_minmax_checker.sv
source/spec_arbiter.sv
source/retire_comparator.sv
source/bitmanip_check_top.sv
tb/tb_bitmanip_check.sv

// File: Makefile
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -Wno-fatal
TOP      ?= tb_bitmanip_check
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test passed"

clean:
	rm -rf $(OBJ_DIR)

// File: tb/tb_bitmanip_check.sv
`include "checker_params.svh"

module tb_bitmanip_check;
    import rvfi_pkg::*;
    import spec_pkg::*;

    localparam int MAX_ROWS = 64;
    localparam logic [6:0] F7_NEG = 7'b0100000;
    localparam logic [6:0] F7_MM  = 7'b0000101;

    // ways a correct claim gets corrupted
    localparam int T_NONE = 0;
    localparam int T_RD   = 1;
    localparam int T_PC   = 2;
    localparam int T_RS2A = 3;
    localparam int T_RDA  = 4;      // rd index and rd data both wrong

    typedef struct {
        retire_t     claim;
        logic        checked;
        fail_kind_e  kind;
        bit          b2b;
    } row_t;

    logic                  clock;
    logic                  reset;
    logic                  rvfi_valid;
    logic [`ILEN-1:0]      rvfi_insn;
    logic [`XLEN-1:0]      rvfi_pc_rdata;
    logic [`XLEN-1:0]      rvfi_pc_wdata;
    logic [`REG_AW-1:0]    rvfi_rs1_addr;
    logic [`REG_AW-1:0]    rvfi_rs2_addr;
    logic [`XLEN-1:0]      rvfi_rs1_rdata;
    logic [`XLEN-1:0]      rvfi_rs2_rdata;
    logic [`REG_AW-1:0]    rvfi_rd_addr;
    logic [`XLEN-1:0]      rvfi_rd_wdata;
    logic                  check_valid;
    logic                  check_fail;
    fail_kind_e            fail_kind;
    logic [`CNT_W-1:0]     checked_count;
    logic [`CNT_W-1:0]     fail_count;

    row_t  rows[$];
    int    launch_cycle[MAX_ROWS];
    int    launched;
    int    cycle;
    int    errors;
    int    timeouts;
    int    exp_checked;
    int    exp_failed;

    bitmanip_check_top i_dut (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    function automatic logic [31:0] enc_i(input logic [11:0] f12, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {f12, rs1, 3'b001, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] rs2, input logic [4:0] rs1,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] ref_clz(input logic [31:0] v);
        int n;
        n = 0;
        while (n < 32 && v[31 - n] == 1'b0)
            n++;
        return 32'(n);
    endfunction

    function automatic logic [31:0] ref_ctz(input logic [31:0] v);
        int n;
        n = 0;
        while (n < 32 && v[n] == 1'b0)
            n++;
        return 32'(n);
    endfunction

    function automatic logic [31:0] ref_cpop(input logic [31:0] v);
        int n;
        n = 0;
        for (int k = 0; k < 32; k++)
            n += int'(v[k]);
        return 32'(n);
    endfunction

    // builds the correct record and tells whether the op is checked
    function automatic logic ref_claim(input logic [31:0] word, input logic [31:0] a,
                                       input logic [31:0] b, input logic [31:0] pc,
                                       output retire_t good);
        logic        hit;
        logic [31:0] val;
        hit = 1'b0;
        val = a + b;                    // unused unless decoded
        good = '0;
        good.valid     = 1'b1;
        good.insn      = word;
        good.pc_rdata  = pc;
        good.pc_wdata  = pc + 32'd4;
        good.rs1_addr  = word[19:15];
        good.rs2_addr  = word[24:20];
        good.rd_addr   = word[11:7];
        good.rs1_rdata = a;
        good.rs2_rdata = b;
        if (word[6:0] == 7'b0010011 && word[14:12] == 3'b001) begin
            good.rs2_addr = '0;         // rs2 bits belong to funct12 here
            hit = 1'b1;
            case (word[31:20])
                12'h600: val = ref_clz(a);
                12'h601: val = ref_ctz(a);
                12'h602: val = ref_cpop(a);
                default: hit = 1'b0;
            endcase
        end else if (word[6:0] == 7'b0110011 && word[31:25] == F7_NEG) begin
            hit = 1'b1;
            case (word[14:12])
                3'b111:  val = a & ~b;
                3'b110:  val = a | ~b;
                3'b100:  val = ~(a ^ b);
                default: hit = 1'b0;
            endcase
        end else if (word[6:0] == 7'b0110011 && word[31:25] == F7_MM) begin
            hit = 1'b1;
            case (word[14:12])
                3'b100:  val = ($signed(a) < $signed(b)) ? a : b;
                3'b101:  val = (a < b) ? a : b;
                3'b110:  val = ($signed(a) > $signed(b)) ? a : b;
                3'b111:  val = (a > b) ? a : b;
                default: hit = 1'b0;
            endcase
        end
        good.rd_wdata = (word[11:7] == 5'd0) ? 32'd0 : val;
        return hit;
    endfunction

    function automatic fail_kind_e expect_kind(input retire_t claim, input retire_t good);
        if (claim.rs1_addr != good.rs1_addr || claim.rs2_addr != good.rs2_addr ||
            claim.rd_addr != good.rd_addr)
            return FAIL_REG;
        if (claim.rd_wdata != good.rd_wdata)
            return FAIL_RD;
        if (claim.pc_wdata != good.pc_wdata)
            return FAIL_PC;
        return FAIL_NONE;
    endfunction

    task automatic add_row(input logic [31:0] word, input logic [31:0] a,
                           input logic [31:0] b, input int tweak, input bit b2b);
        row_t    row;
        retire_t good;
        logic [31:0] pc;
        pc = 32'h0000_1000 + 32'(rows.size() * 4);
        row.checked = ref_claim(word, a, b, pc, good);
        row.claim = good;
        case (tweak)
            T_RD:   row.claim.rd_wdata = good.rd_wdata ^ 32'h0000_0100;
            T_PC:   row.claim.pc_wdata = good.pc_rdata + 32'd2;
            T_RS2A: row.claim.rs2_addr = 5'd3;
            T_RDA: begin
                row.claim.rd_addr  = good.rd_addr ^ 5'd1;
                row.claim.rd_wdata = ~good.rd_wdata;
            end
            default: ;
        endcase
        row.kind = row.checked ? expect_kind(row.claim, good) : FAIL_NONE;
        row.b2b = b2b;
        rows.push_back(row);
    endtask

    task automatic build_table();
        add_row(enc_i(12'h600, 5'd1, 5'd2), 32'h00f0_0000, 32'h0, T_NONE, 1'b0);
        add_row(enc_i(12'h600, 5'd1, 5'd2), 32'h0000_0000, 32'h0, T_NONE, 1'b0);
        add_row(enc_i(12'h600, 5'd3, 5'd4), 32'hffff_ffff, 32'h0, T_NONE, 1'b0);
        add_row(enc_i(12'h601, 5'd5, 5'd6), 32'h0000_0100, 32'h0, T_NONE, 1'b0);
        add_row(enc_i(12'h601, 5'd5, 5'd6), 32'h0000_0000, 32'h0, T_NONE, 1'b0);
        add_row(enc_i(12'h602, 5'd7, 5'd8), 32'hffff_ffff, 32'h0, T_NONE, 1'b0);
        add_row(enc_i(12'h602, 5'd7, 5'd8), 32'h0000_0000, 32'h0, T_NONE, 1'b0);
        add_row(enc_r(F7_NEG, 3'b111, 5'd2, 5'd1, 5'd9), 32'ha5a5_a5a5, 32'h0f0f_0f0f,
                T_NONE, 1'b0);
        add_row(enc_r(F7_NEG, 3'b110, 5'd4, 5'd3, 5'd10), 32'h1234_5678, 32'hffff_0000,
                T_NONE, 1'b0);
        add_row(enc_r(F7_NEG, 3'b100, 5'd6, 5'd5, 5'd11), 32'hffff_ffff, 32'h0, T_NONE, 1'b0);
        // top bit set so signed and unsigned disagree
        add_row(enc_r(F7_MM, 3'b100, 5'd2, 5'd1, 5'd12), 32'h8000_0000, 32'h1, T_NONE, 1'b0);
        add_row(enc_r(F7_MM, 3'b101, 5'd2, 5'd1, 5'd12), 32'h8000_0000, 32'h1, T_NONE, 1'b0);
        add_row(enc_r(F7_MM, 3'b110, 5'd2, 5'd1, 5'd13), 32'hffff_ffff, 32'h7, T_NONE, 1'b0);
        add_row(enc_r(F7_MM, 3'b111, 5'd2, 5'd1, 5'd13), 32'hffff_ffff, 32'h7, T_NONE, 1'b0);
        add_row(enc_r(F7_NEG, 3'b111, 5'd2, 5'd1, 5'd9), 32'hf0f0_f0f0, 32'h0, T_RD, 1'b0);
        add_row(enc_r(F7_NEG, 3'b110, 5'd2, 5'd1, 5'd9), 32'h0000_0001, 32'h2, T_PC, 1'b0);
        add_row(enc_i(12'h600, 5'd1, 5'd2), 32'h0000_ffff, 32'h0, T_RS2A, 1'b0);
        add_row(enc_r(F7_MM, 3'b110, 5'd2, 5'd1, 5'd14), 32'h5, 32'h9, T_RDA, 1'b0);
        add_row(enc_r(F7_NEG, 3'b100, 5'd2, 5'd1, 5'd0), 32'h1357_9bdf, 32'h0, T_NONE, 1'b0);
        add_row(enc_r(F7_MM, 3'b101, 5'd2, 5'd1, 5'd0), 32'h8, 32'h3, T_RD, 1'b0);
        add_row(enc_r(7'b0000000, 3'b000, 5'd2, 5'd1, 5'd3), 32'h10, 32'h20, T_NONE, 1'b0);
        add_row(enc_i(12'h603, 5'd1, 5'd2), 32'h0000_00ff, 32'h0, T_NONE, 1'b0);
        // burst with no idle cycles
        add_row(enc_i(12'h602, 5'd1, 5'd2), 32'h0f0f_0001, 32'h0, T_NONE, 1'b1);
        add_row(enc_r(F7_MM, 3'b100, 5'd4, 5'd3, 5'd5), 32'h7fff_ffff, 32'hffff_fffe,
                T_NONE, 1'b1);
        add_row(enc_r(F7_NEG, 3'b111, 5'd4, 5'd3, 5'd6), 32'hffff_ffff, 32'h1, T_RD, 1'b1);
        add_row(enc_r(7'b0000000, 3'b000, 5'd2, 5'd1, 5'd3), 32'h1, 32'h1, T_NONE, 1'b1);
        add_row(enc_i(12'h601, 5'd7, 5'd8), 32'h8000_0000, 32'h0, T_PC, 1'b1);
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_kind(input fail_kind_e got, input fail_kind_e exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %s, expected %s", $time, what, got.name(),
                     exp.name());
        end
    endtask

    task automatic check_count(input logic [`CNT_W-1:0] got, input logic [`CNT_W-1:0] exp,
                               input string what);
        if (got !== exp) begin
            errors++;
            $display("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic drive_row(input int r);
        rvfi_valid     = 1'b1;
        rvfi_insn      = rows[r].claim.insn;
        rvfi_pc_rdata  = rows[r].claim.pc_rdata;
        rvfi_pc_wdata  = rows[r].claim.pc_wdata;
        rvfi_rs1_addr  = rows[r].claim.rs1_addr;
        rvfi_rs2_addr  = rows[r].claim.rs2_addr;
        rvfi_rs1_rdata = rows[r].claim.rs1_rdata;
        rvfi_rs2_rdata = rows[r].claim.rs2_rdata;
        rvfi_rd_addr   = rows[r].claim.rd_addr;
        rvfi_rd_wdata  = rows[r].claim.rd_wdata;
    endtask

    task automatic drive_rows();
        int gap;
        for (int r = 0; r < rows.size(); r++) begin
            gap = rows[r].b2b ? 0 : int'($urandom % 4);
            repeat (gap) begin
                rvfi_valid = 1'b0;
                @(posedge clock);
                #1;
            end
            drive_row(r);
            launch_cycle[r] = cycle;
            launched = r + 1;
            @(posedge clock);
            #1;
        end
        rvfi_valid = 1'b0;
    endtask

    // sampled late in each cycle
    task automatic watch_results();
        int waited;
        for (int r = 0; r < rows.size(); r++) begin
            waited = 0;
            while ((launched <= r || cycle <= launch_cycle[r]) && waited < 16) begin
                @(posedge clock);
                #3;
                waited++;
            end
            if (launched <= r) begin
                timeouts++;
                $display("row %0d was never driven, giving up on the rest", r);
                return;
            end
            if (rows[r].checked) begin
                waited = 0;
                while (check_valid !== 1'b1 && waited < 8) begin
                    @(posedge clock);
                    #3;
                    waited++;
                end
                if (check_valid !== 1'b1) begin
                    timeouts++;
                    $display("row %0d got no check_valid within 8 cycles", r);
                end else begin
                    if (waited != 0) begin
                        errors++;
                        $display("Error at time %0t: row %0d result %0d cycles late",
                                 $time, r, waited);
                    end
                    check_bit(check_fail, rows[r].kind != FAIL_NONE,
                              $sformatf("row %0d check_fail", r));
                    check_kind(fail_kind, rows[r].kind, $sformatf("row %0d fail_kind", r));
                    exp_checked++;
                    if (rows[r].kind != FAIL_NONE)
                        exp_failed++;
                end
            end else begin
                check_bit(check_valid, 1'b0, $sformatf("row %0d check_valid (undecoded)", r));
            end
        end
    endtask

    initial begin
        reset          = 1'b1;
        rvfi_valid     = 1'b0;
        rvfi_insn      = '0;
        rvfi_pc_rdata  = '0;
        rvfi_pc_wdata  = '0;
        rvfi_rs1_addr  = '0;
        rvfi_rs2_addr  = '0;
        rvfi_rs1_rdata = '0;
        rvfi_rs2_rdata = '0;
        rvfi_rd_addr   = '0;
        rvfi_rd_wdata  = '0;
        cycle       = 0;
        launched    = 0;
        errors      = 0;
        timeouts    = 0;
        exp_checked = 0;
        exp_failed  = 0;
        void'($urandom(32'h29b1));
        build_table();

        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
        check_bit(check_valid, 1'b0, "check_valid after reset");
        check_bit(check_fail, 1'b0, "check_fail after reset");
        check_kind(fail_kind, FAIL_NONE, "fail_kind after reset");
        check_count(checked_count, '0, "checked_count after reset");
        check_count(fail_count, '0, "fail_count after reset");

        fork
            drive_rows();
            watch_results();
        join

        check_count(checked_count, `CNT_W'(exp_checked), "checked_count");
        check_count(fail_count, `CNT_W'(exp_failed), "fail_count");
        $display("value errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: source/bitmanip_check_top.sv
`include "checker_params.svh"

module bitmanip_check_top (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  rvfi_valid,
    input  logic [`ILEN-1:0]      rvfi_insn,
    input  logic [`XLEN-1:0]      rvfi_pc_rdata,
    input  logic [`XLEN-1:0]      rvfi_pc_wdata,
    input  logic [`REG_AW-1:0]    rvfi_rs1_addr,
    input  logic [`REG_AW-1:0]    rvfi_rs2_addr,
    input  logic [`XLEN-1:0]      rvfi_rs1_rdata,
    input  logic [`XLEN-1:0]      rvfi_rs2_rdata,
    input  logic [`REG_AW-1:0]    rvfi_rd_addr,
    input  logic [`XLEN-1:0]      rvfi_rd_wdata,
    output logic                  check_valid,
    output logic                  check_fail,
    output spec_pkg::fail_kind_e  fail_kind,
    output logic [`CNT_W-1:0]     checked_count,
    output logic [`CNT_W-1:0]     fail_count
);
    import rvfi_pkg::*;
    import spec_pkg::*;

    retire_t  retire;
    spec_t    grant_spec;

    spec_if count_if ();
    spec_if logic_if ();
    spec_if minmax_if ();

    assign retire = '{valid: rvfi_valid, insn: rvfi_insn,
                      pc_rdata: rvfi_pc_rdata, pc_wdata: rvfi_pc_wdata,
                      rs1_addr: rvfi_rs1_addr, rs2_addr: rvfi_rs2_addr,
                      rs1_rdata: rvfi_rs1_rdata, rs2_rdata: rvfi_rs2_rdata,
                      rd_addr: rvfi_rd_addr, rd_wdata: rvfi_rd_wdata};

    insn_count_checker  i_count  (.retire(retire), .spec(count_if.chk));
    insn_logic_checker  i_logic  (.retire(retire), .spec(logic_if.chk));
    insn_minmax_checker i_minmax (.retire(retire), .spec(minmax_if.chk));

    spec_arbiter i_arbiter (
        .clock      (clock),
        .reset      (reset),
        .count      (count_if.arb),
        .logic_op   (logic_if.arb),
        .minmax     (minmax_if.arb),
        .grant_spec (grant_spec)
    );

    retire_comparator i_comparator (
        .clock         (clock),
        .reset         (reset),
        .retire        (retire),
        .spec          (grant_spec),
        .check_valid   (check_valid),
        .check_fail    (check_fail),
        .fail_kind     (fail_kind),
        .checked_count (checked_count),
        .fail_count    (fail_count)
    );

endmodule

// File: source/retire_comparator.sv
`include "checker_params.svh"

module retire_comparator (
    input  logic                  clock,
    input  logic                  reset,
    input  rvfi_pkg::retire_t     retire,
    input  spec_pkg::spec_t       spec,
    output logic                  check_valid,
    output logic                  check_fail,
    output spec_pkg::fail_kind_e  fail_kind,
    output logic [`CNT_W-1:0]     checked_count,
    output logic [`CNT_W-1:0]     fail_count
);
    import spec_pkg::*;

    logic        reg_bad;
    logic        rd_bad;
    logic        pc_bad;
    fail_kind_e  kind;

    assign reg_bad = retire.rs1_addr != spec.rs1_addr ||
                     retire.rs2_addr != spec.rs2_addr ||
                     retire.rd_addr  != spec.rd_addr;
    assign rd_bad  = retire.rd_wdata != spec.rd_wdata;
    assign pc_bad  = retire.pc_wdata != spec.pc_wdata;

    // first mismatch wins
    always_comb begin
        if (!spec.valid)
            kind = FAIL_NONE;
        else if (reg_bad)
            kind = FAIL_REG;
        else if (rd_bad)
            kind = FAIL_RD;
        else if (pc_bad)
            kind = FAIL_PC;
        else
            kind = FAIL_NONE;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            check_valid   <= 1'b0;
            check_fail    <= 1'b0;
            fail_kind     <= FAIL_NONE;
            checked_count <= '0;
            fail_count    <= '0;
        end else begin
            check_valid <= spec.valid;
            check_fail  <= kind != FAIL_NONE;
            fail_kind   <= kind;
            if (spec.valid && checked_count != '1)
                checked_count <= checked_count + 1'b1;   // saturates
            if (kind != FAIL_NONE && fail_count != '1)
                fail_count <= fail_count + 1'b1;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clock) reset |=> !check_valid)
        else $error("check_valid raised straight out of reset");

    a_fail_needs_valid: assert property (
        @(posedge clock) disable iff (reset) check_fail |-> check_valid
    ) else $error("check_fail without check_valid");

endmodule

// File: source/spec_arbiter.sv
module spec_arbiter (
    input  logic             clock,
    input  logic             reset,
    spec_if.arb              count,
    spec_if.arb              logic_op,
    spec_if.arb              minmax,
    output spec_pkg::spec_t  grant_spec
);
    import spec_pkg::*;

    spec_t from_count;
    spec_t from_logic;
    spec_t from_minmax;

    assign from_count  = '{valid: count.valid, rs1_addr: count.rs1_addr,
                           rs2_addr: count.rs2_addr, rd_addr: count.rd_addr,
                           rd_wdata: count.rd_wdata, pc_wdata: count.pc_wdata};
    assign from_logic  = '{valid: logic_op.valid, rs1_addr: logic_op.rs1_addr,
                           rs2_addr: logic_op.rs2_addr, rd_addr: logic_op.rd_addr,
                           rd_wdata: logic_op.rd_wdata, pc_wdata: logic_op.pc_wdata};
    assign from_minmax = '{valid: minmax.valid, rs1_addr: minmax.rs1_addr,
                           rs2_addr: minmax.rs2_addr, rd_addr: minmax.rd_addr,
                           rd_wdata: minmax.rd_wdata, pc_wdata: minmax.pc_wdata};

    // fixed priority, idle bus is all zero
    always_comb begin
        if (from_count.valid)
            grant_spec = from_count;
        else if (from_logic.valid)
            grant_spec = from_logic;
        else if (from_minmax.valid)
            grant_spec = from_minmax;
        else
            grant_spec = '0;
    end

    // decoders are disjoint, so never two claims on the same retirement
    a_single_decoder: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0({count.valid, logic_op.valid, minmax.valid})
    ) else $error("more than one checker decoded the same instruction");

endmodule

// File: source/insn_minmax_checker.sv
`include "checker_params.svh"

module insn_minmax_checker (
    input  rvfi_pkg::retire_t  retire,
    spec_if.chk                spec
);
    import rvfi_pkg::*;

    insn_word_u        insn;
    logic              mm_op;
    logic              lt_signed;
    logic              lt_unsigned;
    logic              pick_rs1;
    logic [`XLEN-1:0]  result;

    assign insn = retire.insn;

    // funct7 0000101 holds the whole min/max group
    assign mm_op = retire.valid && insn.r.opcode == `OPC_OP &&
                   insn.r.funct7 == 7'b0000101 && insn.r.funct3[2];

    assign lt_signed   = $signed(retire.rs1_rdata) < $signed(retire.rs2_rdata);
    assign lt_unsigned = retire.rs1_rdata < retire.rs2_rdata;

    // funct3 100 min, 101 minu, 110 max, 111 maxu
    always_comb begin
        case (insn.r.funct3[1:0])
            2'b00:   pick_rs1 = lt_signed;
            2'b01:   pick_rs1 = lt_unsigned;
            2'b10:   pick_rs1 = !lt_signed;
            default: pick_rs1 = !lt_unsigned;
        endcase
    end

    assign result = pick_rs1 ? retire.rs1_rdata : retire.rs2_rdata;

    assign spec.valid    = mm_op;
    assign spec.rs1_addr = insn.r.rs1;
    assign spec.rs2_addr = insn.r.rs2;
    assign spec.rd_addr  = insn.r.rd;
    assign spec.rd_wdata = (insn.r.rd != '0) ? result : '0;
    assign spec.pc_wdata = retire.pc_rdata + (`XLEN)'(4);

endmodule

// File: source/insn_logic_checker.sv
`include "checker_params.svh"

module insn_logic_checker (
    input  rvfi_pkg::retire_t  retire,
    spec_if.chk                spec
);
    import rvfi_pkg::*;

    insn_word_u        insn;
    logic              neg_op;      // OP with funct7 0100000
    logic              dec_andn;
    logic              dec_orn;
    logic              dec_xnor;
    logic [`XLEN-1:0]  result;

    assign insn = retire.insn;

    assign neg_op   = retire.valid && insn.r.opcode == `OPC_OP &&
                      insn.r.funct7 == 7'b0100000;
    assign dec_andn = neg_op && insn.r.funct3 == 3'b111;
    assign dec_orn  = neg_op && insn.r.funct3 == 3'b110;
    assign dec_xnor = neg_op && insn.r.funct3 == 3'b100;

    always_comb begin
        if (dec_andn)
            result = retire.rs1_rdata & ~retire.rs2_rdata;
        else if (dec_orn)
            result = retire.rs1_rdata | ~retire.rs2_rdata;
        else
            result = ~(retire.rs1_rdata ^ retire.rs2_rdata);   // xnor
    end

    assign spec.valid    = dec_andn || dec_orn || dec_xnor;
    assign spec.rs1_addr = insn.r.rs1;
    assign spec.rs2_addr = insn.r.rs2;
    assign spec.rd_addr  = insn.r.rd;
    assign spec.rd_wdata = (insn.r.rd != '0) ? result : '0;   // x0 reads as zero
    assign spec.pc_wdata = retire.pc_rdata + (`XLEN)'(4);

endmodule

// File: source/insn_count_checker.sv
`include "checker_params.svh"

module insn_count_checker (
    input  rvfi_pkg::retire_t  retire,
    spec_if.chk                spec
);
    import rvfi_pkg::*;

    insn_word_u        insn;
    logic              unary_op;    // OP-IMM, funct3 001
    logic              dec_clz;
    logic              dec_ctz;
    logic              dec_cpop;
    logic              lead_done;
    logic              trail_done;
    logic [`XLEN-1:0]  lead;
    logic [`XLEN-1:0]  trail;
    logic [`XLEN-1:0]  ones;
    logic [`XLEN-1:0]  result;

    assign insn = retire.insn;

    assign unary_op = retire.valid && insn.i.opcode == `OPC_OP_IMM && insn.i.funct3 == 3'b001;
    assign dec_clz  = unary_op && insn.i.funct12 == 12'h600;
    assign dec_ctz  = unary_op && insn.i.funct12 == 12'h601;
    assign dec_cpop = unary_op && insn.i.funct12 == 12'h602;

    // all three counts at once, zero operand gives XLEN for clz/ctz
    always_comb begin
        lead       = '0;
        trail      = '0;
        ones       = '0;
        lead_done  = 1'b0;
        trail_done = 1'b0;
        for (int k = `XLEN - 1; k >= 0; k--) begin
            if (retire.rs1_rdata[k])
                lead_done = 1'b1;
            else if (!lead_done)
                lead = lead + 1'b1;
        end
        for (int k = 0; k < `XLEN; k++) begin
            if (retire.rs1_rdata[k])
                trail_done = 1'b1;
            else if (!trail_done)
                trail = trail + 1'b1;
            ones = ones + retire.rs1_rdata[k];
        end
    end

    assign result = dec_clz ? lead :
                    dec_ctz ? trail : ones;

    assign spec.valid    = dec_clz || dec_ctz || dec_cpop;
    assign spec.rs1_addr = insn.i.rs1;
    assign spec.rs2_addr = '0;          // no second source
    assign spec.rd_addr  = insn.i.rd;
    assign spec.rd_wdata = (insn.i.rd != '0) ? result : '0;
    assign spec.pc_wdata = retire.pc_rdata + (`XLEN)'(4);

endmodule

// File: source/spec_if.sv
`include "checker_params.svh"

// spec result of a single checker
interface spec_if;

    logic                valid;
    logic [`REG_AW-1:0]  rs1_addr;
    logic [`REG_AW-1:0]  rs2_addr;
    logic [`REG_AW-1:0]  rd_addr;
    logic [`XLEN-1:0]    rd_wdata;
    logic [`XLEN-1:0]    pc_wdata;

    modport chk (
        output valid,
        output rs1_addr,
        output rs2_addr,
        output rd_addr,
        output rd_wdata,
        output pc_wdata
    );

    modport arb (
        input valid,
        input rs1_addr,
        input rs2_addr,
        input rd_addr,
        input rd_wdata,
        input pc_wdata
    );

endinterface

// File: source/spec_pkg.sv
`include "checker_params.svh"

package spec_pkg;

    // architecturally expected outcome of one retirement
    typedef struct packed {
        logic                valid;
        logic [`REG_AW-1:0]  rs1_addr;
        logic [`REG_AW-1:0]  rs2_addr;
        logic [`REG_AW-1:0]  rd_addr;
        logic [`XLEN-1:0]    rd_wdata;
        logic [`XLEN-1:0]    pc_wdata;
    } spec_t;

    // first mismatch found, in priority order
    typedef enum logic [1:0] {
        FAIL_NONE = 2'd0,
        FAIL_REG  = 2'd1,   // rs1, rs2 or rd index
        FAIL_RD   = 2'd2,   // rd write data
        FAIL_PC   = 2'd3    // next pc
    } fail_kind_e;

endpackage

// File: source/rvfi_pkg.sv
`include "checker_params.svh"

package rvfi_pkg;

    // register-register layout
    typedef struct packed {
        logic [`ILEN-26:0]   funct7;
        logic [`REG_AW-1:0]  rs2;
        logic [`REG_AW-1:0]  rs1;
        logic [2:0]          funct3;
        logic [`REG_AW-1:0]  rd;
        logic [6:0]          opcode;
    } insn_r_t;

    // immediate layout, unary bitmanip ops live in funct12
    typedef struct packed {
        logic [`ILEN-21:0]   funct12;
        logic [`REG_AW-1:0]  rs1;
        logic [2:0]          funct3;
        logic [`REG_AW-1:0]  rd;
        logic [6:0]          opcode;
    } insn_i_t;

    typedef union packed {
        insn_r_t r;
        insn_i_t i;
    } insn_word_u;

    // one retired instruction from the trace
    typedef struct packed {
        logic                valid;
        insn_word_u          insn;
        logic [`XLEN-1:0]    pc_rdata;
        logic [`XLEN-1:0]    pc_wdata;
        logic [`REG_AW-1:0]  rs1_addr;
        logic [`REG_AW-1:0]  rs2_addr;
        logic [`XLEN-1:0]    rs1_rdata;
        logic [`XLEN-1:0]    rs2_rdata;
        logic [`REG_AW-1:0]  rd_addr;
        logic [`XLEN-1:0]    rd_wdata;
    } retire_t;

endpackage

// File: include/checker_params.svh
`ifndef CHECKER_PARAMS_SVH
`define CHECKER_PARAMS_SVH

// datapath and instruction widths, RV32 only
`define XLEN 32
`define ILEN 32

// architectural register index
`define REG_AW 5

// width of the checked and failed counters
`define CNT_W 16

// major opcodes used by the decoders
`define OPC_OP_IMM 7'b0010011
`define OPC_OP     7'b0110011

`endif
